//--- all.f
rtl/cam_qspi_pkg.sv
rtl/pixel_packer.sv
rtl/frame_buffer.sv
rtl/qspi_shifter.sv
rtl/qspi_write_ctrl.sv
rtl/wb_regs.sv
rtl/cam_qspi_top.sv
bench/cam_qspi_asserts.sv
bench/tb_cam_qspi.sv

//--- bench/cam_qspi_asserts.sv
// Bound into qspi_write_ctrl; the low-time counter assumes chip select only falls from idle
`timescale 1ns/1ns

module cam_qspi_asserts (
	input  logic                        WBs_CLK_i,
	input  logic                        WBs_RST_i,
	input  cam_qspi_pkg::qspi_state_e   state_i,
	input  cam_qspi_pkg::qspi_ctl_t     ctl_i,
	input  logic                        quad_ncs_i
);

	localparam int BURST_LOW = cam_qspi_pkg::CMD_BITS + cam_qspi_pkg::ADDR_NIBBLES
	                         + cam_qspi_pkg::BURST_WORDS * cam_qspi_pkg::WORD_NIBBLES;

	logic [10:0] low_cnt;                                 // Cycles of chip select low

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i)
			low_cnt <= '0;
		else if (!quad_ncs_i)
			low_cnt <= low_cnt + 11'd1;
		else
			low_cnt <= '0;
	end

	// ------------------------------
	// Idle after reset and after an abort, gap and bank wait between bursts
	ncs_high_idle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		(state_i inside {cam_qspi_pkg::ST_IDLE, cam_qspi_pkg::ST_GAP,
		                 cam_qspi_pkg::ST_BANK_WAIT}) |-> quad_ncs_i)
		else $error("chip select low outside a burst");

	no_data_in_wait: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		(state_i == cam_qspi_pkg::ST_BANK_WAIT) |->
		!(ctl_i.op inside {cam_qspi_pkg::OP_LOAD_DATA, cam_qspi_pkg::OP_SHIFT_NIB,
		                   cam_qspi_pkg::OP_SHIFT_BIT}))
		else $error("shift or data load while waiting for a bank");

	low_limit: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		low_cnt <= 11'(BURST_LOW))
		else $error("chip select low longer than one burst");

endmodule

bind qspi_write_ctrl cam_qspi_asserts cam_qspi_asserts_i (
	.WBs_CLK_i  (WBs_CLK_i),
	.WBs_RST_i  (WBs_RST_i),
	.state_i    (state_r),
	.ctl_i      (ctl_o),
	.quad_ncs_i (quad_ncs_o)
);

//--- bench/tb_cam_qspi.sv
// Assumes the camera never stops mid-run; expected data comes from the byte queue, bank from counts
`timescale 1ns/1ns

module tb_cam_qspi;

	localparam int RST_CYCLES = 16;
	localparam int BANK_BYTES = 4 * cam_qspi_pkg::BANK_WORDS;
	localparam int BURST_LOW  = cam_qspi_pkg::CMD_BITS + cam_qspi_pkg::ADDR_NIBBLES
	                          + cam_qspi_pkg::BURST_WORDS * cam_qspi_pkg::WORD_NIBBLES;
	localparam int WDOG_CYC   = (4 * BANK_BYTES * 4 + RST_CYCLES + 4000) * 11 / 10; // 4 cyc/byte max

	logic        clk, rst, href, vsync, cyc, stb, we, ncs;
	logic [7:0]  dat;
	logic [31:0] wdat, rdat, rd;
	logic        ack;
	logic [3:0]  qdat;
	logic [31:0] lfsr;
	logic [7:0]  byte_q[$];                               // Every byte taken by the DUT
	int          errs[6];
	string       names[6];
	bit          mode_on, aborting, in_burst;
	int          burst_k, frame_base, cnt, blk, idx, passed;
	logic [7:0]  cmd;
	logic [23:0] addr;
	logic [31:0] word;

	cam_qspi_top cam_qspi_top_i (
		.WBs_CLK_i (clk), .WBs_RST_i (rst), .cam_href_i (href), .cam_vsync_i (vsync),
		.cam_dat_i (dat), .wbs_cyc_i (cyc), .wbs_stb_i (stb), .wbs_we_i (we),
		.wbs_dat_i (wdat), .wbs_ack_o (ack), .wbs_dat_o (rdat),
		.quad_dat_o (qdat), .quad_ncs_o (ncs)
	);

	always #10 clk = ~clk;                                // 20 ns period

	// ------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois, right shift
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[6:0], lfsr[0]};                     // One step per bit
		end
	endtask

	function automatic logic [31:0] expected_word(input int n);
		return {byte_q[4*n], byte_q[4*n+1], byte_q[4*n+2], byte_q[4*n+3]}; // First byte on top
	endfunction

	task automatic report_value(input int t, input logic [31:0] exp, input logic [31:0] act);
		errs[t]++;
		$display("error %s: expected %h actual %h", names[t], exp, act);
	endtask

	task automatic report_text(input int t, input string msg);
		errs[t]++;
		$display("%s: %s", names[t], msg);
	endtask

	task automatic tick;
		@(posedge clk);
		#2;                                               // Drive after the edge
	endtask

	task automatic send_bytes(input int n);
		logic [7:0] b;
		logic [7:0] g;
		repeat (n) begin
			draw_bits(8, b);
			href = 1'b1;
			dat  = b;
			byte_q.push_back(b);
			tick();
			href = 1'b0;
			tick();
			tick();                                       // Three cycles per byte
			draw_bits(3, g);
			if (g == 8'd0)
				tick();                                   // Occasional href gap
		end
	endtask

	task automatic wb_access(input int t, input logic wr, input logic [31:0] d,
	                         output logic [31:0] r);
		cyc  = 1'b1;
		stb  = 1'b1;
		we   = wr;
		wdat = d;
		if (ack !== 1'b0)
			report_text(t, "ack before the strobe was sampled");
		tick();
		if (ack !== 1'b1)
			report_text(t, "no ack one cycle after the strobe");
		r   = rdat;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		tick();
		if (ack !== 1'b0)
			report_text(t, "ack lasted more than one cycle");
	endtask

	task automatic finish_test(input int t);
		$display("test %s: %s, %0d errors", names[t], (errs[t] == 0) ? "ok" : "failed", errs[t]);
	endtask

	// ------------------------------
	// QSPI decoder, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && ncs === 1'b0) begin
			if (!in_burst) begin
				in_burst = 1'b1;
				cnt      = 0;
				blk      = byte_q.size() / 4 / cam_qspi_pkg::BANK_WORDS;
				if (!mode_on)
					report_text(aborting ? 5 : 1, "chip select fell with write mode off");
				if (burst_k % 4 == 0)
					frame_base = (blk - 1) * cam_qspi_pkg::BANK_WORDS; // Last full bank
				if (blk < 1 || ((blk - 1) % 2) != (burst_k / 4) % 2)
					report_value(4, 32'((burst_k / 4) % 2), 32'((blk + 1) % 2));
				if (rdat[0] == 1'((burst_k / 4) % 2))
					report_text(4, "burst started while the camera fills the same bank");
			end
			if (cnt < 8) begin
				if (qdat[3:1] != 3'b000)
					report_text(2, "upper lines active during the command");
				cmd = {cmd[6:0], qdat[0]};
			end else if (cnt < 14) begin
				addr = {addr[19:0], qdat};
			end else begin
				word = {word[27:0], qdat};
			end
			cnt++;
			if (cnt == 8 && cmd !== cam_qspi_pkg::QPI_WRITE_CMD)
				report_value(2, 32'(cam_qspi_pkg::QPI_WRITE_CMD), 32'(cmd));
			if (cnt == 14 && addr !== 24'(burst_k * cam_qspi_pkg::BURST_BYTES))
				report_value(2, 32'(burst_k * cam_qspi_pkg::BURST_BYTES), 32'(addr));
			if (cnt > 14 && (cnt - 14) % 8 == 0) begin
				idx = frame_base + (burst_k % 4) * cam_qspi_pkg::BURST_WORDS + (cnt - 14) / 8 - 1;
				if (word !== expected_word(idx))
					report_value(3, expected_word(idx), word);
			end
		end else if (in_burst) begin
			in_burst = 1'b0;
			if (cnt != BURST_LOW && !aborting)
				report_value(2, 32'(BURST_LOW), 32'(cnt));
			burst_k++;
		end
	end

	// Watchdog
	initial begin
		#(WDOG_CYC * 20);
		$display("timeout: the run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// ------------------------------
	initial begin
		clk   = 0;
		rst   = 1;
		href  = 0;
		vsync = 0;
		dat   = '0;
		cyc   = 0;
		stb   = 0;
		we    = 0;
		wdat  = '0;
		lfsr  = 32'hc96a_1196;
		names = '{"host_rw", "idle_ncs", "burst_format", "burst_data", "bank_rule", "mode_abort"};
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 0;
		tick();
		// Host read of status, vsync low then high
		wb_access(0, 1'b0, '0, rd);
		if (rd !== 32'h0)
			report_value(0, 32'h0, rd);
		vsync = 1'b1;
		tick();
		wb_access(0, 1'b0, '0, rd);
		if (rd !== 32'h100)
			report_value(0, 32'h100, rd);
		// Full bank with mode off
		send_bytes(BANK_BYTES);
		wb_access(0, 1'b0, '0, rd);
		if (rd !== {23'h0, 1'b1, 7'h0, 1'((byte_q.size() / BANK_BYTES) % 2)})
			report_value(0, {23'h0, 1'b1, 7'h0, 1'((byte_q.size() / BANK_BYTES) % 2)}, rd);
		finish_test(0);
		finish_test(1);
		// Write mode, then three more banks
		mode_on = 1'b1;
		wb_access(2, 1'b1, 32'(cam_qspi_pkg::MODE_WRITE), rd);
		send_bytes(3 * BANK_BYTES);
		wait (ncs === 1'b0);
		repeat (300) tick();
		if (burst_k != 12)
			report_value(2, 32'd12, 32'(burst_k));
		finish_test(2);
		finish_test(3);
		finish_test(4);
		// Clear the mode mid-burst
		aborting = 1'b1;
		mode_on  = 1'b0;
		wb_access(5, 1'b1, 32'h0, rd);
		if (ncs !== 1'b1)
			report_text(5, "chip select still low two cycles after mode clear");
		repeat (2200) tick();
		finish_test(5);
		passed = 0;
		foreach (errs[i])
			if (errs[i] == 0)
				passed++;
		$display("summary: %0d tests passed, %0d failed, %0d errors", passed, 6 - passed,
		         errs.sum());
		if (passed == 6)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- rtl/cam_qspi_pkg.sv
// Fixed geometry: two 512-word banks, 512-byte bursts, Quad Write opcode only, no read mode
package cam_qspi_pkg;

	// ------------------------------
	// Data path geometry
	localparam int WORD_W      = 32;  // Frame buffer word
	localparam int BANK_WORDS  = 512; // Words per ping-pong bank
	localparam int BANK_ADDR_W = 9;   // Word address inside a bank
	localparam int BURST_WORDS = 128; // One burst is 512 bytes
	localparam int BURST_BYTES = 512; // External address step per burst

	// ------------------------------
	// QSPI SRAM protocol
	localparam int         QSPI_ADDR_W   = 24;
	localparam logic [7:0] QPI_WRITE_CMD = 8'h38; // Quad Write
	localparam int         CMD_BITS      = 8;     // Serial on line 0
	localparam int         ADDR_NIBBLES  = 6;
	localparam int         WORD_NIBBLES  = 8;
	localparam int         IDLE_GAP      = 2;     // Minimum deselect between bursts

	// Control register mode field
	localparam logic [1:0] MODE_WRITE = 2'b10;

	// Camera word on its way into the frame buffer
	typedef struct packed {
		logic [WORD_W-1:0]    data;
		logic [BANK_ADDR_W:0] addr; // Bank bit on top
		logic                 we;   // One-cycle write pulse
	} cam_word_t;

	// Shifter operation, one per cycle
	typedef enum logic [2:0] {
		OP_HOLD,
		OP_LOAD_CMD,
		OP_LOAD_ADDR,
		OP_LOAD_DATA,
		OP_SHIFT_BIT,
		OP_SHIFT_NIB,
		OP_IDLE_LOW
	} qspi_op_e;

	typedef struct packed {
		qspi_op_e               op;
		logic [QSPI_ADDR_W-1:0] addr; // Burst start address
	} qspi_ctl_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_ADDR,
		ST_DATA,
		ST_GAP,
		ST_BANK_WAIT
	} qspi_state_e;

endpackage

//--- rtl/cam_qspi_top.sv
// Single clock domain; camera bytes arrive as a synchronous href/vsync qualified stream
`timescale 1ns/1ns

module cam_qspi_top (
	input  logic        WBs_CLK_i,
	input  logic        WBs_RST_i,
	// Camera
	input  logic        cam_href_i,
	input  logic        cam_vsync_i,
	input  logic [7:0]  cam_dat_i,
	// Host
	input  logic        wbs_cyc_i,
	input  logic        wbs_stb_i,
	input  logic        wbs_we_i,
	input  logic [31:0] wbs_dat_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o,
	// QSPI SRAM
	output logic [3:0]  quad_dat_o,
	output logic        quad_ncs_o
);

	cam_qspi_pkg::cam_word_t                  cam_word;
	cam_qspi_pkg::qspi_ctl_t                  qspi_ctl;
	logic [cam_qspi_pkg::BANK_ADDR_W:0]       rd_addr;
	logic [cam_qspi_pkg::WORD_W-1:0]          rd_data;
	logic                                     cam_bank;
	logic                                     mode_write;

	assign cam_bank = cam_word.addr[cam_qspi_pkg::BANK_ADDR_W]; // Bank the camera is filling

	// ------------------------------
	pixel_packer pixel_packer_i (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.cam_href_i  (cam_href_i),
		.cam_vsync_i (cam_vsync_i),
		.cam_dat_i   (cam_dat_i),
		.cam_word_o  (cam_word)
	);

	frame_buffer frame_buffer_i (
		.WBs_CLK_i  (WBs_CLK_i),
		.cam_word_i (cam_word),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data)
	);

	qspi_write_ctrl qspi_write_ctrl_i (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.mode_write_i (mode_write),
		.cam_bank_i   (cam_bank),
		.rd_addr_o    (rd_addr),
		.ctl_o        (qspi_ctl),
		.quad_ncs_o   (quad_ncs_o)
	);

	qspi_shifter qspi_shifter_i (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.ctl_i      (qspi_ctl),
		.word_i     (rd_data),
		.quad_dat_o (quad_dat_o)
	);

	wb_regs wb_regs_i (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.wbs_cyc_i    (wbs_cyc_i),
		.wbs_stb_i    (wbs_stb_i),
		.wbs_we_i     (wbs_we_i),
		.wbs_dat_i    (wbs_dat_i),
		.wbs_ack_o    (wbs_ack_o),
		.wbs_dat_o    (wbs_dat_o),
		.cam_vsync_i  (cam_vsync_i),
		.cam_bank_i   (cam_bank),
		.mode_write_o (mode_write)
	);

endmodule

//--- rtl/frame_buffer.sv
// Read data appears one cycle after rd_addr_i; a read of the word being written returns old data
`timescale 1ns/1ns

module frame_buffer (
	input  logic                                 WBs_CLK_i,
	input  cam_qspi_pkg::cam_word_t              cam_word_i,
	input  logic [cam_qspi_pkg::BANK_ADDR_W:0]   rd_addr_i,
	output logic [cam_qspi_pkg::WORD_W-1:0]      rd_data_o
);

	localparam int DEPTH = 2 * cam_qspi_pkg::BANK_WORDS;  // Both banks in one array

	// ------------------------------
	// Storage, bank bit is the top address bit
	logic [cam_qspi_pkg::WORD_W-1:0] mem [DEPTH];

	// Camera write port
	always_ff @(posedge WBs_CLK_i) begin
		if (cam_word_i.we)
			mem[cam_word_i.addr] <= cam_word_i.data;
	end

	// QSPI-side read port, always reading
	// The controller holds the address steady for the cycle before each load
	always_ff @(posedge WBs_CLK_i) begin
		rd_data_o <= mem[rd_addr_i];                      // Registered output
	end

endmodule

//--- rtl/pixel_packer.sv
// Camera bytes need at least 3 cycles between them; the first byte of a group lands in bits 31:24
`timescale 1ns/1ns

module pixel_packer (
	input  logic                   WBs_CLK_i,
	input  logic                   WBs_RST_i,
	input  logic                   cam_href_i,
	input  logic                   cam_vsync_i,
	input  logic [7:0]             cam_dat_i,
	output cam_qspi_pkg::cam_word_t cam_word_o
);

	typedef enum logic [1:0] {
		BYTE0,
		BYTE1,
		BYTE2,
		BYTE3
	} byte_state_e;

	byte_state_e byte_st;                                 // Bytes already held
	logic [23:0] hold_r;                                  // First three bytes of a group
	logic [cam_qspi_pkg::WORD_W-1:0]        data_r;       // Completed word
	logic [cam_qspi_pkg::BANK_ADDR_W:0]     addr_r;       // Wraps over both banks
	logic                                   we_r;
	logic                                   byte_vld;

	assign byte_vld = cam_href_i & cam_vsync_i;           // Active line and frame

	// ------------------------------
	// Byte count and write strobe
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			byte_st <= BYTE0;
			we_r    <= 1'b0;
			addr_r  <= '0;
		end else begin
			we_r <= 1'b0;                                 // Pulse by default
			if (we_r)
				addr_r <= addr_r + 1'b1;                  // Advance once the word is written
			if (byte_vld) begin
				case (byte_st)
					BYTE0: byte_st <= BYTE1;
					BYTE1: byte_st <= BYTE2;
					BYTE2: byte_st <= BYTE3;
					BYTE3: begin
						byte_st <= BYTE0;
						we_r    <= 1'b1;                  // Word complete
					end
					default: byte_st <= BYTE0;
				endcase
			end
		end
	end

	// Payload shift, big-endian
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_vld) begin
			hold_r <= {hold_r[15:0], cam_dat_i};
			if (byte_st == BYTE3)
				data_r <= {hold_r, cam_dat_i};
		end
	end

	always_comb begin
		cam_word_o.data = data_r;
		cam_word_o.addr = addr_r;
		cam_word_o.we   = we_r;
	end

endmodule

//--- rtl/qspi_shifter.sv
// Only one of the three shift registers is non-zero at a time; quad_dat_o is their head bits OR-ed
`timescale 1ns/1ns

module qspi_shifter (
	input  logic                              WBs_CLK_i,
	input  logic                              WBs_RST_i,
	input  cam_qspi_pkg::qspi_ctl_t           ctl_i,
	input  logic [cam_qspi_pkg::WORD_W-1:0]   word_i,
	output logic [3:0]                        quad_dat_o
);

	logic [cam_qspi_pkg::CMD_BITS-1:0]    cmd_r;          // Serial opcode, MSB out first
	logic [cam_qspi_pkg::QSPI_ADDR_W-1:0] addr_r;         // Address nibbles
	logic [cam_qspi_pkg::WORD_W-1:0]      data_r;         // Data nibbles

	// ------------------------------
	// Load and shift by op
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			cmd_r  <= '0;
			addr_r <= '0;
			data_r <= '0;
		end else begin
			case (ctl_i.op)
				cam_qspi_pkg::OP_LOAD_CMD: begin
					cmd_r  <= cam_qspi_pkg::QPI_WRITE_CMD;
					addr_r <= '0;
					data_r <= '0;
				end
				cam_qspi_pkg::OP_LOAD_ADDR: begin
					cmd_r  <= '0;                         // Drop last command bit
					addr_r <= ctl_i.addr;
				end
				cam_qspi_pkg::OP_LOAD_DATA: begin
					addr_r <= '0;                         // Drop last address nibble
					data_r <= word_i;                     // Replaces previous word
				end
				cam_qspi_pkg::OP_SHIFT_BIT:
					cmd_r <= {cmd_r[cam_qspi_pkg::CMD_BITS-2:0], 1'b0};
				cam_qspi_pkg::OP_SHIFT_NIB: begin
					addr_r <= {addr_r[cam_qspi_pkg::QSPI_ADDR_W-5:0], 4'h0};
					data_r <= {data_r[cam_qspi_pkg::WORD_W-5:0], 4'h0};
				end
				cam_qspi_pkg::OP_IDLE_LOW: begin
					cmd_r  <= '0;                         // All lines low
					addr_r <= '0;
					data_r <= '0;
				end
				default: ;                                // OP_HOLD
			endcase
		end
	end

	// Head of whichever register is active
	assign quad_dat_o = {3'b000, cmd_r[cam_qspi_pkg::CMD_BITS-1]}
	                  | addr_r[cam_qspi_pkg::QSPI_ADDR_W-1 -: 4]
	                  | data_r[cam_qspi_pkg::WORD_W-1 -: 4];

endmodule

//--- rtl/qspi_write_ctrl.sv
// Bursts restart at address 0 and bank 0 whenever the mode is set; a mode clear aborts mid-burst
`timescale 1ns/1ns

module qspi_write_ctrl (
	input  logic                                 WBs_CLK_i,
	input  logic                                 WBs_RST_i,
	input  logic                                 mode_write_i,
	input  logic                                 cam_bank_i,
	output logic [cam_qspi_pkg::BANK_ADDR_W:0]   rd_addr_o,
	output cam_qspi_pkg::qspi_ctl_t              ctl_o,
	output logic                                 quad_ncs_o
);

	cam_qspi_pkg::qspi_state_e state_r;
	logic [2:0]                                 phase_r;     // Bit or nibble within a phase
	logic [6:0]                                 word_cnt_r;  // Word within the burst
	logic [cam_qspi_pkg::BANK_ADDR_W-1:0]       word_ptr_r;  // Next word to fetch
	logic [cam_qspi_pkg::QSPI_ADDR_W-1:0]       burst_addr_r;
	logic                                       send_bank_r; // Bank being sent
	logic                                       gap_done;
	logic                                       last_word;
	logic                                       burst_go;

	assign gap_done  = (phase_r == 3'(cam_qspi_pkg::IDLE_GAP - 1));
	assign last_word = (word_cnt_r == 7'(cam_qspi_pkg::BURST_WORDS - 1));
	// Bank b only goes out while the camera fills the other bank
	assign burst_go = mode_write_i &&
	                  (((state_r == cam_qspi_pkg::ST_BANK_WAIT) && (cam_bank_i != send_bank_r)) ||
	                   ((state_r == cam_qspi_pkg::ST_GAP) && gap_done && (word_ptr_r != '0)));
	assign rd_addr_o = {send_bank_r, word_ptr_r};        // Stable the cycle before each load

	// ------------------------------
	// Shifter op decode
	always_comb begin
		ctl_o.addr = burst_addr_r;
		ctl_o.op   = cam_qspi_pkg::OP_HOLD;
		if (!mode_write_i) begin
			ctl_o.op = cam_qspi_pkg::OP_IDLE_LOW;        // Abort drives lines low
		end else begin
			case (state_r)
				cam_qspi_pkg::ST_IDLE:
					ctl_o.op = cam_qspi_pkg::OP_IDLE_LOW;
				cam_qspi_pkg::ST_CMD:
					ctl_o.op = (phase_r == 3'(cam_qspi_pkg::CMD_BITS - 1)) ?
					           cam_qspi_pkg::OP_LOAD_ADDR : cam_qspi_pkg::OP_SHIFT_BIT;
				cam_qspi_pkg::ST_ADDR:
					ctl_o.op = (phase_r == 3'(cam_qspi_pkg::ADDR_NIBBLES - 1)) ?
					           cam_qspi_pkg::OP_LOAD_DATA : cam_qspi_pkg::OP_SHIFT_NIB;
				cam_qspi_pkg::ST_DATA: begin
					if (phase_r != 3'(cam_qspi_pkg::WORD_NIBBLES - 1))
						ctl_o.op = cam_qspi_pkg::OP_SHIFT_NIB;
					else if (last_word)
						ctl_o.op = cam_qspi_pkg::OP_IDLE_LOW; // End of burst
					else
						ctl_o.op = cam_qspi_pkg::OP_LOAD_DATA;
				end
				default:                                  // ST_GAP, ST_BANK_WAIT
					if (burst_go)
						ctl_o.op = cam_qspi_pkg::OP_LOAD_CMD;
			endcase
		end
	end

	// ------------------------------
	// Sequencing and chip select
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state_r      <= cam_qspi_pkg::ST_IDLE;
			phase_r      <= '0;
			word_cnt_r   <= '0;
			word_ptr_r   <= '0;
			burst_addr_r <= '0;
			send_bank_r  <= 1'b0;
			quad_ncs_o   <= 1'b1;
		end else if (!mode_write_i) begin
			state_r    <= cam_qspi_pkg::ST_IDLE;
			quad_ncs_o <= 1'b1;                           // Deselect at once
		end else if (burst_go) begin
			state_r    <= cam_qspi_pkg::ST_CMD;
			phase_r    <= '0;
			quad_ncs_o <= 1'b0;                           // Low with the first command bit
		end else begin
			case (state_r)
				cam_qspi_pkg::ST_IDLE: begin
					state_r      <= cam_qspi_pkg::ST_BANK_WAIT; // Fresh start, wait for bank 1
					phase_r      <= '0;
					word_cnt_r   <= '0;
					word_ptr_r   <= '0;
					burst_addr_r <= '0;
					send_bank_r  <= 1'b0;
				end
				cam_qspi_pkg::ST_CMD: begin
					phase_r <= phase_r + 1'b1;
					if (phase_r == 3'(cam_qspi_pkg::CMD_BITS - 1))
						state_r <= cam_qspi_pkg::ST_ADDR;
				end
				cam_qspi_pkg::ST_ADDR: begin
					phase_r <= phase_r + 1'b1;
					if (phase_r == 3'(cam_qspi_pkg::ADDR_NIBBLES - 1)) begin
						state_r    <= cam_qspi_pkg::ST_DATA;
						phase_r    <= '0;
						word_cnt_r <= '0;
						word_ptr_r <= word_ptr_r + 1'b1;  // First word taken
					end
				end
				cam_qspi_pkg::ST_DATA: begin
					phase_r <= phase_r + 1'b1;            // Wraps 7 to 0
					if (phase_r == 3'(cam_qspi_pkg::WORD_NIBBLES - 1)) begin
						if (last_word) begin
							state_r      <= cam_qspi_pkg::ST_GAP;
							quad_ncs_o   <= 1'b1;
							burst_addr_r <= burst_addr_r + 24'(cam_qspi_pkg::BURST_BYTES);
							if (word_ptr_r == '0)
								send_bank_r <= ~send_bank_r; // Fourth burst of the bank
						end else begin
							word_cnt_r <= word_cnt_r + 1'b1;
							word_ptr_r <= word_ptr_r + 1'b1;
						end
					end
				end
				cam_qspi_pkg::ST_GAP: begin
					phase_r <= phase_r + 1'b1;
					if (gap_done) begin
						state_r <= cam_qspi_pkg::ST_BANK_WAIT; // Only reached at bank end
						phase_r <= '0;
					end
				end
				default: ;                                // ST_BANK_WAIT holds
			endcase
		end
	end

endmodule

//--- rtl/wb_regs.sv
// No address decode: every write hits the control register, every read returns the status word
`timescale 1ns/1ns

module wb_regs (
	input  logic        WBs_CLK_i,
	input  logic        WBs_RST_i,
	input  logic        wbs_cyc_i,
	input  logic        wbs_stb_i,
	input  logic        wbs_we_i,
	input  logic [31:0] wbs_dat_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o,
	input  logic        cam_vsync_i,
	input  logic        cam_bank_i,
	output logic        mode_write_o
);

	logic [1:0] ctrl_mode_r;                              // Control bits 1:0
	logic       ack_nxt;
	logic       wr_en;

	// ------------------------------
	// Handshake
	assign ack_nxt = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;  // One ack per strobe
	assign wr_en   = ack_nxt & wbs_we_i;                  // Stored with the ack edge

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i)
			wbs_ack_o <= 1'b0;
		else
			wbs_ack_o <= ack_nxt;                         // Single-cycle pulse
	end

	// Control register
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i)
			ctrl_mode_r <= '0;                            // Not write mode
		else if (wr_en)
			ctrl_mode_r <= wbs_dat_i[1:0];
	end

	assign mode_write_o = (ctrl_mode_r == cam_qspi_pkg::MODE_WRITE);

	// Status word: vsync at bit 8, camera bank at bit 0
	assign wbs_dat_o = {23'h0, cam_vsync_i, 7'h0, cam_bank_i};

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the simulator output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cam_qspi -f all.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }
